// ==== processor.f ====
hdl/isa_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/forward_unit.sv
hdl/alu.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/processor.sv
bench/processor_memories.sv
bench/processor_tb.sv

// ==== bench/processor_tb.sv ====
`timescale 1ns/1ps

module processor_tb;

    localparam int reset_pc   = 16;
    localparam int run_cycles = 60; // every program parks in a jump-to-self
    localparam int num_tests  = 5;
    localparam int max_cycles = num_tests * (run_cycles + 3) + 85;

    localparam logic [4:0] opc_rtype = 5'd0;
    localparam logic [4:0] opc_j     = 5'd1;
    localparam logic [4:0] opc_bne   = 5'd2;
    localparam logic [4:0] opc_addi  = 5'd5;
    localparam logic [4:0] opc_blt   = 5'd6;
    localparam logic [4:0] opc_sw    = 5'd7;
    localparam logic [4:0] opc_lw    = 5'd8;

    localparam logic [4:0] fn_add = 5'd0;
    localparam logic [4:0] fn_sub = 5'd1;
    localparam logic [4:0] fn_and = 5'd2;
    localparam logic [4:0] fn_or  = 5'd3;
    localparam logic [4:0] fn_sll = 5'd4;
    localparam logic [4:0] fn_sra = 5'd5;

    localparam logic [31:0] trap_add   = 32'd1;
    localparam logic [31:0] trap_addi  = 32'd2;
    localparam logic [31:0] trap_sub   = 32'd3;
    localparam logic [4:0]  status_num = 5'd30;

    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] value;
    } reg_write_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] value;
    } store_t;

    logic        clock = 1'b0;
    logic        rst;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] q_dmem;
    logic        ctrl_writeEnable;
    logic [4:0]  ctrl_writeReg;
    logic [4:0]  ctrl_readRegA;
    logic [4:0]  ctrl_readRegB;
    logic [31:0] data_writeReg;
    logic [31:0] data_readRegA;
    logic [31:0] data_readRegB;

    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         prog_len;
    string      test_name = "init";
    reg_write_t seen_writes[$];
    reg_write_t exp_writes[$];
    store_t     seen_stores[$];
    store_t     exp_stores[$];
    reg_write_t port_write;
    store_t     port_store;

    processor #(.reset_pc(reset_pc)) i_dut (.*);

    processor_memories i_mem (.*);

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    // port log, sampled mid-cycle
    always @(negedge clock) begin
        if (rst === 1'b0) begin
            if (ctrl_writeEnable) begin
                if (ctrl_writeReg == 5'd0) begin
                    error_count++;
                    $display("error %s: register 0 was written with %h", test_name, data_writeReg);
                end
                port_write.dest  = ctrl_writeReg;
                port_write.value = data_writeReg;
                seen_writes.push_back(port_write);
            end
            if (wren) begin
                port_store.addr  = address_dmem;
                port_store.value = data;
                seen_stores.push_back(port_store);
            end
        end
    end

    function automatic logic [31:0] r_type(input logic [4:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] shamt);
        return {opc_rtype, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic logic [31:0] i_type(input logic [4:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [16:0] imm);
        return {opc, rd, rs, imm};
    endfunction

    function automatic logic [31:0] jump_to(input int target);
        return {opc_j, target[26:0]};
    endfunction

    task automatic next_cycle;
        @(posedge clock);
        #2;
    endtask

    task automatic apply_reset;
        rst = 1'b1;
        repeat (3) begin
            next_cycle();
        end
        rst = 1'b0;
    endtask

    task automatic new_program(input string name);
        int k;
        for (k = 0; k < 256; k++) begin
            i_mem.imem[k] = 32'd0; // all-zero word is a nop
        end
        prog_len  = 0;
        test_name = name;
        seen_writes.delete();
        seen_stores.delete();
        exp_writes.delete();
        exp_stores.delete();
    endtask

    task automatic emit(input logic [31:0] word);
        i_mem.imem[reset_pc + prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_write(input logic [4:0] dest, input logic [31:0] value);
        reg_write_t w;
        w.dest  = dest;
        w.value = value;
        exp_writes.push_back(w);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] value);
        store_t s;
        s.addr  = addr;
        s.value = value;
        exp_stores.push_back(s);
    endtask

    task automatic compare_logs;
        int         k;
        reg_write_t exp_w;
        reg_write_t got_w;
        store_t     exp_s;
        store_t     got_s;
        check_count += 2;
        if (seen_writes.size() != exp_writes.size()) begin
            error_count++;
            $display("error %s: register writes expected %0d actual %0d",
                     test_name, exp_writes.size(), seen_writes.size());
        end
        if (seen_stores.size() != exp_stores.size()) begin
            error_count++;
            $display("error %s: stores expected %0d actual %0d",
                     test_name, exp_stores.size(), seen_stores.size());
        end
        for (k = 0; k < exp_writes.size() && k < seen_writes.size(); k++) begin
            exp_w = exp_writes[k];
            got_w = seen_writes[k];
            check_count++;
            if (got_w !== exp_w) begin
                error_count++;
                $display("error %s: write %0d expected r%0d=%h actual r%0d=%h", test_name, k,
                         exp_w.dest, exp_w.value, got_w.dest, got_w.value);
            end
        end
        for (k = 0; k < exp_stores.size() && k < seen_stores.size(); k++) begin
            exp_s = exp_stores[k];
            got_s = seen_stores[k];
            check_count++;
            if (got_s !== exp_s) begin
                error_count++;
                $display("error %s: store %0d expected [%h]=%h actual [%h]=%h", test_name, k,
                         exp_s.addr, exp_s.value, got_s.addr, got_s.value);
            end
        end
    endtask

    task automatic run_program;
        apply_reset();
        repeat (run_cycles) begin
            next_cycle();
        end
        compare_logs();
    endtask

    task automatic test_reset;
        int cyc;
        new_program("reset");
        emit(i_type(opc_addi, 5'd1, 5'd0, 17'd9));
        emit(jump_to(reset_pc + 1));
        apply_reset();
        for (cyc = 0; cyc < 5; cyc++) begin
            @(negedge clock);
            check_count++;
            if (cyc == 0 && address_imem !== 32'(reset_pc)) begin
                error_count++;
                $display("error %s: address_imem expected %h actual %h",
                         test_name, 32'(reset_pc), address_imem);
            end
            if (cyc < 4 && (ctrl_writeEnable !== 1'b0 || wren !== 1'b0)) begin
                error_count++;
                $display("error %s: cycle %0d ctrl_writeEnable/wren expected 0/0 actual %b/%b",
                         test_name, cyc, ctrl_writeEnable, wren);
            end
            // first instruction reaches the write ports four cycles after its fetch
            if (cyc == 4 && (ctrl_writeEnable !== 1'b1 || ctrl_writeReg !== 5'd1 ||
                             data_writeReg !== 32'd9)) begin
                error_count++;
                $display("error %s: cycle 4 write expected 1 r1=%h actual %b r%0d=%h", test_name,
                         32'd9, ctrl_writeEnable, ctrl_writeReg, data_writeReg);
            end
            next_cycle();
        end
    endtask

    task automatic test_arith;
        logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9;
        new_program("arith_forwarding");
        emit(i_type(opc_addi, 5'd1, 5'd0, 17'd12));
        emit(i_type(opc_addi, 5'd2, 5'd0, -17'd3));
        emit(r_type(fn_add, 5'd3, 5'd1, 5'd2, 5'd0)); // r2 from mem stage, r1 from writeback
        emit(r_type(fn_sub, 5'd4, 5'd1, 5'd3, 5'd0));
        emit(i_type(opc_addi, 5'd0, 5'd4, 17'd7)); // r0 target
        emit(i_type(opc_addi, 5'd10, 5'd0, 17'd1));
        emit(r_type(fn_and, 5'd5, 5'd4, 5'd2, 5'd0)); // r4 via register file
        emit(r_type(fn_or, 5'd6, 5'd5, 5'd1, 5'd0));
        emit(r_type(fn_sll, 5'd7, 5'd6, 5'd0, 5'd4));
        emit(r_type(fn_sra, 5'd8, 5'd2, 5'd0, 5'd1));
        emit(r_type(fn_add, 5'd9, 5'd7, 5'd8, 5'd0));
        emit(jump_to(reset_pc + 11));
        r1 = 32'd12;
        r2 = -32'd3;
        r3 = r1 + r2;
        r4 = r1 - r3;
        r5 = r4 & r2;
        r6 = r5 | r1;
        r7 = r6 << 4;
        r8 = $signed(r2) >>> 1;
        r9 = r7 + r8;
        expect_write(5'd1, r1);
        expect_write(5'd2, r2);
        expect_write(5'd3, r3);
        expect_write(5'd4, r4);
        expect_write(5'd10, 32'd1);
        expect_write(5'd5, r5);
        expect_write(5'd6, r6);
        expect_write(5'd7, r7);
        expect_write(5'd8, r8);
        expect_write(5'd9, r9);
        run_program();
    endtask

    task automatic test_load_store;
        logic [31:0] base;
        logic [31:0] val;
        new_program("load_store");
        emit(i_type(opc_addi, 5'd1, 5'd0, 17'd100));
        emit(i_type(opc_addi, 5'd2, 5'd0, 17'd55));
        emit(i_type(opc_sw, 5'd2, 5'd1, 17'd4)); // mem[r1+4] = r2
        emit(i_type(opc_sw, 5'd1, 5'd1, -17'd2));
        emit(i_type(opc_lw, 5'd3, 5'd1, 17'd4));
        emit(r_type(fn_add, 5'd4, 5'd3, 5'd2, 5'd0)); // load-use
        emit(i_type(opc_lw, 5'd5, 5'd1, -17'd2));
        emit(i_type(opc_addi, 5'd6, 5'd0, 17'd7));
        emit(r_type(fn_add, 5'd7, 5'd5, 5'd6, 5'd0));
        emit(jump_to(reset_pc + 9));
        base = 32'd100;
        val  = 32'd55;
        expect_write(5'd1, base);
        expect_write(5'd2, val);
        expect_store(base + 32'd4, val);
        expect_store(base - 32'd2, base);
        expect_write(5'd3, val);
        expect_write(5'd4, val + val);
        expect_write(5'd5, base);
        expect_write(5'd6, 32'd7);
        expect_write(5'd7, base + 32'd7);
        run_program();
    endtask

    task automatic test_control;
        new_program("control_flow");
        emit(i_type(opc_addi, 5'd1, 5'd0, 17'd5));
        emit(i_type(opc_addi, 5'd2, 5'd0, 17'd9));
        emit(i_type(opc_bne, 5'd1, 5'd2, 17'd2)); // taken, to 5
        emit(i_type(opc_addi, 5'd3, 5'd0, 17'd1));
        emit(i_type(opc_addi, 5'd4, 5'd0, 17'd1));
        emit(i_type(opc_bne, 5'd1, 5'd1, 17'd3)); // not taken
        emit(i_type(opc_addi, 5'd5, 5'd0, 17'd2));
        emit(i_type(opc_blt, 5'd2, 5'd1, 17'd2)); // 9 < 5, not taken
        emit(i_type(opc_addi, 5'd6, 5'd0, 17'd3));
        emit(i_type(opc_blt, 5'd1, 5'd2, 17'd2)); // taken, to 12
        emit(i_type(opc_addi, 5'd7, 5'd0, 17'd4));
        emit(i_type(opc_addi, 5'd8, 5'd0, 17'd4));
        emit(i_type(opc_addi, 5'd9, 5'd0, -17'd1));
        emit(i_type(opc_blt, 5'd9, 5'd0, 17'd2)); // signed -1 < 0, to 16
        emit(i_type(opc_addi, 5'd10, 5'd0, 17'd6));
        emit(i_type(opc_addi, 5'd11, 5'd0, 17'd6));
        emit(jump_to(reset_pc + 19));
        emit(i_type(opc_addi, 5'd12, 5'd0, 17'd7));
        emit(i_type(opc_addi, 5'd14, 5'd0, 17'd7));
        emit(i_type(opc_addi, 5'd13, 5'd0, 17'd8));
        emit(jump_to(reset_pc + 20));
        expect_write(5'd1, 32'd5);
        expect_write(5'd2, 32'd9);
        expect_write(5'd5, 32'd2);
        expect_write(5'd6, 32'd3);
        expect_write(5'd9, -32'd1);
        expect_write(5'd13, 32'd8);
        run_program();
    endtask

    task automatic test_overflow;
        logic [31:0] big;
        logic [31:0] min_neg;
        new_program("overflow_exceptions");
        emit(i_type(opc_addi, 5'd1, 5'd0, 17'd1));
        emit(r_type(fn_sll, 5'd1, 5'd1, 5'd0, 5'd30));
        emit(r_type(fn_add, 5'd2, 5'd1, 5'd1, 5'd0)); // overflow
        emit(r_type(fn_add, 5'd3, 5'd30, 5'd0, 5'd0)); // code through bypass
        emit(r_type(fn_sll, 5'd4, 5'd1, 5'd0, 5'd1));
        emit(i_type(opc_addi, 5'd5, 5'd4, -17'd1)); // overflow, most negative minus one
        emit(r_type(fn_or, 5'd7, 5'd30, 5'd0, 5'd0));
        emit(r_type(fn_sub, 5'd8, 5'd4, 5'd1, 5'd0)); // overflow
        emit(r_type(fn_add, 5'd9, 5'd30, 5'd30, 5'd0));
        emit(r_type(fn_sub, 5'd10, 5'd5, 5'd1, 5'd0)); // r5 still zero
        emit(jump_to(reset_pc + 10));
        big     = 32'd1 << 30;
        min_neg = big << 1;
        expect_write(5'd1, 32'd1);
        expect_write(5'd1, big);
        expect_write(status_num, trap_add);
        expect_write(5'd3, trap_add);
        expect_write(5'd4, min_neg);
        expect_write(status_num, trap_addi);
        expect_write(5'd7, trap_addi);
        expect_write(status_num, trap_sub);
        expect_write(5'd9, trap_sub + trap_sub);
        expect_write(5'd10, 32'd0 - big);
        run_program();
    endtask

    initial begin
        rst = 1'b1;
        test_reset();
        test_arith();
        test_load_store();
        test_control();
        test_overflow();
        $display("%0d checks run, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== bench/processor_memories.sv ====
`timescale 1ns/1ps

module processor_memories (
    input  logic        clock,
    input  logic        rst,
    input  logic [31:0] address_imem,
    output logic [31:0] q_imem,
    input  logic [31:0] address_dmem,
    input  logic [31:0] data,
    input  logic        wren,
    output logic [31:0] q_dmem,
    input  logic        ctrl_writeEnable,
    input  logic [4:0]  ctrl_writeReg,
    input  logic [31:0] data_writeReg,
    input  logic [4:0]  ctrl_readRegA,
    input  logic [4:0]  ctrl_readRegB,
    output logic [31:0] data_readRegA,
    output logic [31:0] data_readRegB
);

    logic [31:0] imem [0:255]; // loaded by the testbench before each program
    logic [31:0] dmem [0:255];
    logic [31:0] regs [0:31];

    // zero-wait reads
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // r0 reads zero, a same-cycle write is seen at once
    assign data_readRegA = (ctrl_readRegA == 5'd0) ? 32'd0 :
                           (ctrl_writeEnable && ctrl_writeReg == ctrl_readRegA) ? data_writeReg :
                           regs[ctrl_readRegA];
    assign data_readRegB = (ctrl_readRegB == 5'd0) ? 32'd0 :
                           (ctrl_writeEnable && ctrl_writeReg == ctrl_readRegB) ? data_writeReg :
                           regs[ctrl_readRegB];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int k = 0; k < 256; k++) begin
                dmem[k] <= 32'd0;
            end
            for (int k = 0; k < 32; k++) begin
                regs[k] <= 32'd0;
            end
        end else begin
            if (wren) begin
                dmem[address_dmem[7:0]] <= data;
            end
            if (ctrl_writeEnable && ctrl_writeReg != 5'd0) begin
                regs[ctrl_writeReg] <= data_writeReg;
            end
        end
    end

endmodule

// ==== hdl/processor.sv ====
`timescale 1ns/1ps

module processor import isa_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clock,
    input  logic            rst,

    // instruction memory
    output logic [xlen-1:0] address_imem,
    input  logic [xlen-1:0] q_imem,

    // data memory
    output logic [xlen-1:0] address_dmem,
    output logic [xlen-1:0] data,
    output logic            wren,
    input  logic [xlen-1:0] q_dmem,

    // register file
    output logic            ctrl_writeEnable,
    output reg_addr_t       ctrl_writeReg,
    output reg_addr_t       ctrl_readRegA,
    output reg_addr_t       ctrl_readRegB,
    output logic [xlen-1:0] data_writeReg,
    input  logic [xlen-1:0] data_readRegA,
    input  logic [xlen-1:0] data_readRegB
);

    fd_t             fd;
    dx_t             dx;
    xm_t             xm;
    wb_t             wb;
    redirect_t       redirect;
    logic            stall;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clock        (clock),
        .rst          (rst),
        .stall        (stall),
        .redirect     (redirect),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .fd           (fd)
    );

    decode_stage i_decode (
        .clock         (clock),
        .rst           (rst),
        .fd            (fd),
        .redirect      (redirect),
        .data_readRegA (data_readRegA),
        .data_readRegB (data_readRegB),
        .ctrl_readRegA (ctrl_readRegA),
        .ctrl_readRegB (ctrl_readRegB),
        .stall         (stall),
        .dx            (dx)
    );

    // one bypass mux per execute operand
    forward_unit fwd_a (
        .src       (dx.src_a),
        .reg_value (dx.a),
        .xm        (xm),
        .wb        (wb),
        .operand   (operand_a)
    );

    forward_unit fwd_b (
        .src       (dx.src_b),
        .reg_value (dx.b),
        .xm        (xm),
        .wb        (wb),
        .operand   (operand_b)
    );

    execute_stage i_execute (
        .clock     (clock),
        .rst       (rst),
        .dx        (dx),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .redirect  (redirect),
        .xm        (xm)
    );

    mem_wb_stage i_mem_wb (
        .clock            (clock),
        .rst              (rst),
        .xm               (xm),
        .q_dmem           (q_dmem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .wb               (wb),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .data_writeReg    (data_writeReg)
    );

endmodule

// ==== hdl/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage import isa_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  xm_t             xm,
    input  logic [xlen-1:0] q_dmem,
    output logic [xlen-1:0] address_dmem,
    output logic [xlen-1:0] data,
    output logic            wren,
    output wb_t             wb,
    output logic            ctrl_writeEnable,
    output reg_addr_t       ctrl_writeReg,
    output logic [xlen-1:0] data_writeReg
);

    // dmem is zero-wait, q_dmem returns in the same cycle
    assign address_dmem = xm.result;
    assign data         = xm.store_data;
    assign wren         = xm.is_store;

    always_ff @(posedge clock) begin
        if (rst) begin
            wb.wr_en <= 1'b0;
        end else begin
            wb.wr_en <= xm.wr_en;
        end
    end

    always_ff @(posedge clock) begin
        wb.dest  <= xm.dest;
        wb.value <= xm.is_load ? q_dmem : xm.result;
    end

    assign ctrl_writeEnable = wb.wr_en;
    assign ctrl_writeReg    = wb.dest;
    assign data_writeReg    = wb.value;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import isa_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  dx_t             dx,
    input  logic [xlen-1:0] operand_a,
    input  logic [xlen-1:0] operand_b,
    output redirect_t       redirect,
    output xm_t             xm
);

    logic [xlen-1:0] alu_b;
    alu_op_t         alu_op;
    logic [xlen-1:0] alu_result;
    logic            overflow;
    logic            not_equal;
    logic            less_than;
    logic            branch_taken;
    logic            exc;
    xm_t             xm_d;

    // address math for lw and sw goes through the adder too
    assign alu_b  = dx.use_imm ? dx.imm : operand_b;
    assign alu_op = dx.use_imm ? alu_add : dx.alu_op;

    alu i_alu (
        .a         (operand_a),
        .b         (alu_b),
        .op        (alu_op),
        .shamt     (dx.shamt),
        .result    (alu_result),
        .overflow  (overflow),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign branch_taken = (dx.is_bne && not_equal) || (dx.is_blt && less_than);

    always_comb begin
        redirect.taken  = branch_taken || dx.is_jump;
        redirect.target = dx.is_jump ? dx.target : dx.pc_next + dx.imm;
    end

    // only add, addi and sub carry a nonzero code
    assign exc = (dx.exc_code != 2'd0) && overflow;

    always_comb begin
        xm_d.result     = exc ? xlen'(dx.exc_code) : alu_result;
        xm_d.store_data = operand_b;
        xm_d.dest       = exc ? status_reg : dx.dest;
        xm_d.wr_en      = dx.wr_en || exc; // trap writes even when rd is r0
        xm_d.is_load    = dx.is_load;
        xm_d.is_store   = dx.is_store;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            xm <= '0;
        end else begin
            xm <= xm_d;
        end
    end

    // load data is not ready in memory stage, the decode stall must cover this
    no_load_bypass: assert property (@(posedge clock) disable iff (rst)
        (xm.is_load && xm.wr_en) |-> (xm.dest != dx.src_a && xm.dest != dx.src_b));

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu import isa_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_t         op,
    input  logic [4:0]      shamt,
    output logic [xlen-1:0] result,
    output logic            overflow,
    output logic            not_equal,
    output logic            less_than
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            ovf_add;
    logic            ovf_sub;

    assign sum  = a + b;
    assign diff = a - b;

    // sign of result disagrees with operands of like sign
    assign ovf_add = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    assign ovf_sub = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);

    always_comb begin
        overflow = 1'b0;
        case (op)
            alu_add: begin
                result   = sum;
                overflow = ovf_add;
            end
            alu_sub: begin
                result   = diff;
                overflow = ovf_sub;
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_sll: result = a << shamt;
            alu_sra: result = $signed(a) >>> shamt;
            default: result = '0;
        endcase
    end

    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b)); // signed compare for blt

endmodule

// ==== hdl/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit import isa_pkg::*; (
    input  reg_addr_t       src,
    input  logic [xlen-1:0] reg_value,
    input  xm_t             xm,
    input  wb_t             wb,
    output logic [xlen-1:0] operand
);

    logic hit_xm;
    logic hit_wb;

    // r0 is hard zero, never bypassed
    assign hit_xm = (src != '0) && xm.wr_en && (xm.dest == src);
    assign hit_wb = (src != '0) && wb.wr_en && (wb.dest == src);

    always_comb begin
        if (hit_xm) begin
            operand = xm.result; // youngest result wins
        end else if (hit_wb) begin
            operand = wb.value;
        end else begin
            operand = reg_value;
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import isa_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  fd_t             fd,
    input  redirect_t       redirect,
    input  logic [xlen-1:0] data_readRegA,
    input  logic [xlen-1:0] data_readRegB,
    output reg_addr_t       ctrl_readRegA,
    output reg_addr_t       ctrl_readRegB,
    output logic            stall,
    output dx_t             dx
);

    instr_t    instr;
    logic      is_rtype, is_addi, is_lw, is_sw, is_bne, is_blt, is_j;
    logic      uses_a, uses_b;
    reg_addr_t read_a, read_b;
    dx_t       dx_d;

    assign instr = fd.instr;

    assign is_rtype = (instr.opcode == op_rtype);
    assign is_addi  = (instr.opcode == op_addi);
    assign is_lw    = (instr.opcode == op_lw);
    assign is_sw    = (instr.opcode == op_sw);
    assign is_bne   = (instr.opcode == op_bne);
    assign is_blt   = (instr.opcode == op_blt);
    assign is_j     = (instr.opcode == op_j);

    assign uses_a = is_rtype | is_addi | is_lw | is_sw | is_bne | is_blt;
    assign uses_b = is_rtype | is_sw | is_bne | is_blt;

    // branches compare rd with rs
    // stores put the base rs on A and the data rd on B
    always_comb begin
        read_a = (is_bne || is_blt) ? instr.rd : instr.rs;
        if (is_bne || is_blt) begin
            read_b = instr.rs;
        end else if (is_sw) begin
            read_b = instr.rd;
        end else begin
            read_b = instr.rt;
        end
    end

    assign ctrl_readRegA = read_a;
    assign ctrl_readRegB = read_b;

    always_comb begin
        dx_d.pc_next  = fd.pc_next;
        dx_d.a        = data_readRegA;
        dx_d.b        = data_readRegB;
        dx_d.imm      = {{(xlen-17){instr[16]}}, instr[16:0]};
        dx_d.target   = {{(xlen-27){instr[26]}}, instr[26:0]};
        dx_d.src_a    = uses_a ? read_a : '0; // unused ports never match
        dx_d.src_b    = uses_b ? read_b : '0;
        dx_d.dest     = instr.rd;
        dx_d.wr_en    = (is_rtype | is_addi | is_lw) && (instr.rd != '0);
        dx_d.alu_op   = instr.alu_op;
        dx_d.shamt    = instr.shamt;
        dx_d.use_imm  = is_addi | is_lw | is_sw;
        dx_d.is_load  = is_lw;
        dx_d.is_store = is_sw;
        dx_d.is_bne   = is_bne;
        dx_d.is_blt   = is_blt;
        dx_d.is_jump  = is_j;
        if (is_addi) begin
            dx_d.exc_code = code_addi;
        end else if (is_rtype && instr.alu_op == alu_add) begin
            dx_d.exc_code = code_add;
        end else if (is_rtype && instr.alu_op == alu_sub) begin
            dx_d.exc_code = code_sub;
        end else begin
            dx_d.exc_code = 2'd0; // no overflow trap
        end
    end

    // load in execute feeding this instruction
    assign stall = dx.is_load && dx.wr_en &&
                   ((dx.dest == dx_d.src_a) || (dx.dest == dx_d.src_b));

    always_ff @(posedge clock) begin
        if (rst || stall || redirect.taken) begin
            dx <= '0; // bubble
        end else begin
            dx <= dx_d;
        end
    end

    // fetch must present the stalled instruction again
    stalled_fd_held: assert property (@(posedge clock) disable iff (rst)
        stall |=> $stable(fd));

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import isa_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clock,
    input  logic            rst,
    input  logic            stall,
    input  redirect_t       redirect,
    input  logic [xlen-1:0] q_imem,
    output logic [xlen-1:0] address_imem,
    output fd_t             fd
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus1;

    assign pc_plus1 = pc + xlen'(1);
    assign address_imem = pc; // imem is read with the current pc

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= pc_plus1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            fd.pc_next <= '0;
            fd.instr   <= instr_t'(nop_instr);
        end else if (redirect.taken) begin
            fd.pc_next <= pc_plus1;
            fd.instr   <= instr_t'(nop_instr); // wrong-path fetch
        end else if (!stall) begin
            fd.pc_next <= pc_plus1;
            fd.instr   <= instr_t'(q_imem);
        end
    end

    // a load sits in execute whenever stall is high, so no branch can resolve
    stall_vs_redirect: assert property (@(posedge clock) disable iff (rst)
        !(stall && redirect.taken));

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [4:0] {
        op_rtype = 5'd0,
        op_j     = 5'd1,
        op_bne   = 5'd2,
        op_addi  = 5'd5,
        op_blt   = 5'd6,
        op_sw    = 5'd7,
        op_lw    = 5'd8
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_t;

    localparam reg_addr_t status_reg = 5'd30; // overflow codes land here

    localparam logic [1:0] code_add  = 2'd1;
    localparam logic [1:0] code_addi = 2'd2;
    localparam logic [1:0] code_sub  = 2'd3;

    localparam logic [xlen-1:0] nop_instr = '0;

    // immediate is bits 16:0, jump target is bits 26:0 of the same word
    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rd;
        reg_addr_t  rs;
        reg_addr_t  rt;
        logic [4:0] shamt;
        alu_op_t    alu_op;
        logic [1:0] spare;
    } instr_t;

    typedef struct packed {
        logic [xlen-1:0] pc_next;
        instr_t          instr;
    } fd_t;

    typedef struct packed {
        logic [xlen-1:0] pc_next;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm;     // sign-extended
        logic [xlen-1:0] target;  // sign-extended
        reg_addr_t       src_a;   // zero when port A is unused
        reg_addr_t       src_b;
        reg_addr_t       dest;
        logic            wr_en;
        alu_op_t         alu_op;
        logic [4:0]      shamt;
        logic            use_imm;
        logic            is_load;
        logic            is_store;
        logic            is_bne;
        logic            is_blt;
        logic            is_jump;
        logic [1:0]      exc_code;
    } dx_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
        reg_addr_t       dest;
        logic            wr_en;
        logic            is_load;
        logic            is_store;
    } xm_t;

    typedef struct packed {
        reg_addr_t       dest;
        logic            wr_en;
        logic [xlen-1:0] value;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage
